/* design/exec_pkg.sv */
// Execute pipeline package
// Word types, ALU micro-operations and the records passed between the
// stages of the RV32I execute pipeline

`default_nettype none

package exec_pkg;

    //==========================================================================
    // Basic types
    //==========================================================================

    // One RV32 data word or byte address
    typedef logic [31:0] data_word_t;

    // Architectural register index, x0 is hardwired to zero
    typedef logic [4:0] reg_idx_t;

    // ALU micro-operations
    // Control transfers take the lowest codes so a single compare finds them
    typedef enum logic [3:0] {
        JAL  = 4'd0,
        BEQ  = 4'd1,
        BNE  = 4'd2,
        BLT  = 4'd3,
        BLTU = 4'd4,
        BGE  = 4'd5,
        BGEU = 4'd6,
        ADD  = 4'd7,
        AND  = 4'd8,
        OR   = 4'd9,
        XOR  = 4'd10,
        SLTI = 4'd11,
        SLTU = 4'd12,
        SLL  = 4'd13,
        SRL  = 4'd14,
        SRA  = 4'd15
    } alu_uop_t;

    // Every code below this one is a jump or a branch
    localparam logic [3:0] LAST_JUMP_UOP = 4'd7;

    // Link address increments for full width and compressed jumps
    localparam data_word_t LINK_STEP_FULL = 32'd4;
    localparam data_word_t LINK_STEP_COMP = 32'd2;

    //==========================================================================
    // Stage records
    //==========================================================================

    // Decoded packet handed over by the issue logic
    typedef struct packed {
        logic       valid;
        data_word_t rs1_value;
        data_word_t rs2_value;
        data_word_t imm;
        data_word_t instr_addr;
        alu_uop_t   uop;
        logic       use_imm;
        logic       is_jalr;
        logic       is_cjump;
        reg_idx_t   rd;
    } exec_issue_t;

    // Stage one register, feeds the ALU directly
    typedef struct packed {
        logic       valid;
        data_word_t operand_a;
        data_word_t operand_b;
        data_word_t instr_addr;
        alu_uop_t   uop;
        logic       is_cjump;
        data_word_t target;
        reg_idx_t   rd;
    } alu_in_t;

    // Write-back and redirect word leaving the pipeline
    typedef struct packed {
        logic       wb_valid;
        reg_idx_t   wb_rd;
        data_word_t wb_data;
        logic       redirect;
        data_word_t redirect_target;
    } exec_result_t;

endpackage : exec_pkg

`default_nettype wire

/* design/operand_select.sv */
// Execute stage one
// Picks operand B, computes the jump or branch target and registers the
// packet in front of the ALU

`default_nettype none

module operand_select (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  exec_pkg::exec_issue_t issue_i,
    output exec_pkg::alu_in_t     alu_in_o
);

    import exec_pkg::*;

    data_word_t operand_b;
    data_word_t target_base;
    data_word_t target_sum;
    data_word_t target;
    alu_in_t    stage_d;
    alu_in_t    stage_q;

    //==========================================================================
    // Operand and target selection
    //==========================================================================

    // Immediate forms replace rs2 with the sign-extended immediate
    assign operand_b = issue_i.use_imm ? issue_i.imm : issue_i.rs2_value;

    // JALR jumps relative to rs1, every other transfer relative to the PC
    assign target_base = issue_i.is_jalr ? issue_i.rs1_value : issue_i.instr_addr;
    assign target_sum  = target_base + issue_i.imm;

    // The JALR target always has its lowest bit forced to zero
    assign target = issue_i.is_jalr ? {target_sum[31:1], 1'b0} : target_sum;

    always_comb begin
        stage_d            = '0;
        stage_d.valid      = issue_i.valid;
        stage_d.operand_a  = issue_i.rs1_value;
        stage_d.operand_b  = operand_b;
        stage_d.instr_addr = issue_i.instr_addr;
        stage_d.uop        = issue_i.uop;
        stage_d.is_cjump   = issue_i.is_cjump;
        stage_d.target     = target;
        stage_d.rd         = issue_i.rd;
    end

    //==========================================================================
    // Stage register
    //==========================================================================

    // The whole packet clears on reset, the valid strobe included
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            stage_q <= '0;
        end else begin
            stage_q <= stage_d;
        end
    end

    assign alu_in_o = stage_q;

endmodule : operand_select

`default_nettype wire

/* design/arithmetic_logic_unit.sv */
// Arithmetic logic unit
// Purely combinational RV32I integer, compare, shift and link operations,
// plus detection of control transfers for the redirect logic

`default_nettype none

module arithmetic_logic_unit (
    input  exec_pkg::alu_in_t    alu_in_i,
    output exec_pkg::data_word_t result_o,
    output logic                 data_valid_o,
    output logic                 is_branch_o
);

    import exec_pkg::*;

    data_word_t adder_result;
    logic       less_than_s;
    logic       less_than_u;
    logic       is_equal;
    logic [4:0] shift_amount;
    data_word_t sll_result;
    data_word_t srl_result;
    data_word_t sra_result;
    data_word_t and_result;
    data_word_t or_result;
    data_word_t xor_result;
    data_word_t link_addr;

    //==========================================================================
    // Adder and comparators
    //==========================================================================

    // Used by ADD, ADDI and the immediate forms built on them
    assign adder_result = alu_in_i.operand_a + alu_in_i.operand_b;

    // Signed and unsigned orderings of the same pair of bit patterns
    assign less_than_s = $signed(alu_in_i.operand_a) < $signed(alu_in_i.operand_b);
    assign less_than_u = alu_in_i.operand_a < alu_in_i.operand_b;
    assign is_equal    = alu_in_i.operand_a == alu_in_i.operand_b;

    //==========================================================================
    // Shifter
    //==========================================================================

    // RV32 shifts only look at the low five bits of rs2 or the immediate
    assign shift_amount = alu_in_i.operand_b[4:0];

    assign sll_result = alu_in_i.operand_a << shift_amount;
    assign srl_result = alu_in_i.operand_a >> shift_amount;

    // Arithmetic shift replicates the sign bit of operand A
    assign sra_result = data_word_t'($signed(alu_in_i.operand_a) >>> shift_amount);

    //==========================================================================
    // Bitwise logic and link address
    //==========================================================================

    assign and_result = alu_in_i.operand_a & alu_in_i.operand_b;
    assign or_result  = alu_in_i.operand_a | alu_in_i.operand_b;
    assign xor_result = alu_in_i.operand_a ^ alu_in_i.operand_b;

    // A compressed jump is only two bytes long
    assign link_addr = alu_in_i.instr_addr
                     + (alu_in_i.is_cjump ? LINK_STEP_COMP : LINK_STEP_FULL);

    //==========================================================================
    // Result select
    //==========================================================================

    // Branch and set-less-than codes return a single flag bit
    always_comb begin
        case (alu_in_i.uop)
            JAL:     result_o = link_addr;
            BEQ:     result_o = {31'b0, is_equal};
            BNE:     result_o = {31'b0, !is_equal};
            BLT:     result_o = {31'b0, less_than_s};
            BLTU:    result_o = {31'b0, less_than_u};
            BGE:     result_o = {31'b0, !less_than_s};
            BGEU:    result_o = {31'b0, !less_than_u};
            ADD:     result_o = adder_result;
            AND:     result_o = and_result;
            OR:      result_o = or_result;
            XOR:     result_o = xor_result;
            SLTI:    result_o = {31'b0, less_than_s};
            SLTU:    result_o = {31'b0, less_than_u};
            SLL:     result_o = sll_result;
            SRL:     result_o = srl_result;
            SRA:     result_o = sra_result;
            default: result_o = '0;
        endcase
    end

    assign data_valid_o = alu_in_i.valid;

    // A valid control transfer; the link address of JAL is never zero, so a
    // jump is always seen as taken downstream
    assign is_branch_o = alu_in_i.valid && (alu_in_i.uop < LAST_JUMP_UOP);

endmodule : arithmetic_logic_unit

`default_nettype wire

/* design/branch_resolve.sv */
// Execute stage two
// Resolves taken jumps and branches into a redirect and registers the
// write-back word for the register file

`default_nettype none

module branch_resolve (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  exec_pkg::data_word_t   alu_result_i,
    input  logic                   alu_valid_i,
    input  logic                   is_branch_i,
    input  exec_pkg::data_word_t   target_i,
    input  exec_pkg::reg_idx_t     rd_i,
    output exec_pkg::exec_result_t result_o
);

    import exec_pkg::*;

    logic         taken;
    logic         write_back;
    exec_result_t result_d;

    //==========================================================================
    // Redirect and write-back decision
    //==========================================================================

    // The ALU leaves a nonzero result for every taken transfer
    assign taken = is_branch_i && (alu_result_i != '0);

    // Writes to x0 are dropped, which also covers every branch
    assign write_back = alu_valid_i && (rd_i != '0);

    // Fields of an inactive half are held at zero
    always_comb begin
        result_d          = '0;
        result_d.wb_valid = write_back;
        result_d.redirect = taken;
        if (write_back) begin
            result_d.wb_rd   = rd_i;
            result_d.wb_data = alu_result_i;
        end
        if (taken) begin
            result_d.redirect_target = target_i;
        end
    end

    //==========================================================================
    // Output register
    //==========================================================================

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            result_o <= '0;
        end else begin
            result_o <= result_d;
        end
    end

endmodule : branch_resolve

`default_nettype wire

/* design/execute_pipeline.sv */
// Execute pipeline top level
// Two-stage RV32I execute path: operand select, ALU, branch resolve

`default_nettype none

module execute_pipeline (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  exec_pkg::exec_issue_t  issue_i,
    output exec_pkg::exec_result_t result_o
);

    import exec_pkg::*;

    alu_in_t    alu_in;
    data_word_t alu_result;
    logic       alu_valid;
    logic       alu_is_branch;

    // First cycle, ends in the stage register
    operand_select i_operand_select (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .issue_i  (issue_i),
        .alu_in_o (alu_in)
    );

    arithmetic_logic_unit i_alu (
        .alu_in_i     (alu_in),
        .result_o     (alu_result),
        .data_valid_o (alu_valid),
        .is_branch_o  (alu_is_branch)
    );

    // Second cycle, target and rd bypass the ALU from the stage register
    branch_resolve i_branch_resolve (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .alu_result_i (alu_result),
        .alu_valid_i  (alu_valid),
        .is_branch_i  (alu_is_branch),
        .target_i     (alu_in.target),
        .rd_i         (alu_in.rd),
        .result_o     (result_o)
    );

endmodule : execute_pipeline

`default_nettype wire

/* tests/exec_monitor.sv */
// Execute pipeline result monitor
// Holds expected results for two cycles, in step with the pipeline, and
// compares them with the DUT outputs, one report line per test

`default_nettype none

module exec_monitor (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   check_i,
    input  exec_pkg::exec_result_t result_i,
    output int                     pass_count_o,
    output int                     fail_count_o
);

    import exec_pkg::*;

    // Names and values of the tests still on their way through the DUT
    string        name_q[$];
    exec_result_t expect_q[$];

    // One flag per pipeline stage, set while a checked packet is in flight
    logic [1:0]   check_dly;
    int           pass_count = 0;
    int           fail_count = 0;

    assign pass_count_o = pass_count;
    assign fail_count_o = fail_count;

    // Called by the stimulus in the same time step as the packet is driven
    task automatic expect_result(input string name, input exec_result_t expected);
        name_q.push_back(name);
        expect_q.push_back(expected);
    endtask

    function automatic string format_result(input exec_result_t res);
        return $sformatf("wb %b rd x%0d data %h redirect %b target %h",
                         res.wb_valid, res.wb_rd, res.wb_data,
                         res.redirect, res.redirect_target);
    endfunction

    //==========================================================================
    // Delay line, same depth as the DUT
    //==========================================================================

    always @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            check_dly <= 2'b00;
        end else begin
            check_dly <= {check_dly[0], check_i};
        end
    end

    //==========================================================================
    // Compare
    //==========================================================================

    // The falling edge is well clear of the register updates on the rising one
    always @(negedge clk_i) begin
        string        name;
        exec_result_t expected;
        if (arst_n_i && check_dly[1]) begin
            if (name_q.size() == 0) begin
                fail_count++;
                $display("Monitor error: a checked result arrived with nothing expected");
            end else begin
                name     = name_q.pop_front();
                expected = expect_q.pop_front();
                if (result_i === expected) begin
                    pass_count++;
                    $display("ok     %s", name);
                end else begin
                    fail_count++;
                    $display("FAILED %s expected %s actual %s", name,
                             format_result(expected), format_result(result_i));
                end
            end
        end
    end

endmodule : exec_monitor

`default_nettype wire

/* tests/execute_pipeline_chk.sv */
// Execute pipeline assertions
// Reset and valid rules of the result port, bound into the top level

`default_nettype none

module execute_pipeline_chk (
    input logic                   clk_i,
    input logic                   arst_n_i,
    input exec_pkg::exec_issue_t  issue_i,
    input exec_pkg::exec_result_t result_o
);

    // Read by the testbench at the end of the run
    int error_count = 0;

    // Every output field stays zero while reset is held
    reset_outputs_zero: assert property (
        @(posedge clk_i) !arst_n_i |-> (result_o == '0)
    ) else begin
        error_count++;
        $error("Result port is not zero during reset");
    end

    // An empty issue slot never turns into a write-back
    idle_no_write_back: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        !issue_i.valid |-> ##2 !result_o.wb_valid
    ) else begin
        error_count++;
        $error("Write-back seen two cycles after an invalid issue slot");
    end

    // A redirect always traces back to a valid packet two cycles earlier
    redirect_needs_valid: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        result_o.redirect |-> $past(issue_i.valid, 2)
    ) else begin
        error_count++;
        $error("Redirect without a valid packet two cycles before");
    end

endmodule : execute_pipeline_chk

bind execute_pipeline execute_pipeline_chk i_chk (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .issue_i  (issue_i),
    .result_o (result_o)
);

`default_nettype wire

/* tests/tb_execute_pipeline.sv */
// Execute pipeline testbench
// Directed table of RV32I packets followed by a random phase checked
// against a reference model, all results compared by the monitor

`default_nettype none

module tb_execute_pipeline;

    import exec_pkg::*;

    localparam int RESET_CYCLES   = 8;
    localparam int RANDOM_COUNT   = 32;
    localparam int PIPE_DEPTH     = 2;
    localparam int TIMEOUT_MARGIN = 20;
    localparam int DRIVE_DELAY    = 10;

    logic         clk = 1'b0;
    logic         arst_n;
    logic         check_en;
    exec_issue_t  issue;
    exec_result_t result;
    int           pass_count;
    int           fail_count;
    int           cycle_count = 0;
    int           cycle_limit;
    data_word_t   rng_state;

    // Directed stimulus with the hand-worked results
    string        case_name[$];
    exec_issue_t  case_issue[$];
    exec_result_t case_expect[$];

    execute_pipeline i_dut (
        .clk_i    (clk),
        .arst_n_i (arst_n),
        .issue_i  (issue),
        .result_o (result)
    );

    exec_monitor i_monitor (
        .clk_i        (clk),
        .arst_n_i     (arst_n),
        .check_i      (check_en),
        .result_i     (result),
        .pass_count_o (pass_count),
        .fail_count_o (fail_count)
    );

    always #50 clk = ~clk;

    //==========================================================================
    // Packet helpers and reference model
    //==========================================================================

    // Flags are packed as {use_imm, is_jalr, is_cjump}
    function automatic exec_issue_t make_issue(input alu_uop_t uop, input data_word_t rs1,
                                               input data_word_t rs2, input data_word_t imm,
                                               input data_word_t addr, input logic [2:0] flags,
                                               input reg_idx_t rd);
        exec_issue_t pkt;
        pkt            = '0;
        pkt.valid      = 1'b1;
        pkt.uop        = uop;
        pkt.rs1_value  = rs1;
        pkt.rs2_value  = rs2;
        pkt.imm        = imm;
        pkt.instr_addr = addr;
        {pkt.use_imm, pkt.is_jalr, pkt.is_cjump} = flags;
        pkt.rd         = rd;
        return pkt;
    endfunction

    function automatic exec_result_t make_result(input logic wb, input reg_idx_t rd,
                                                 input data_word_t data, input logic redir,
                                                 input data_word_t target);
        exec_result_t res;
        res.wb_valid        = wb;
        res.wb_rd           = rd;
        res.wb_data         = data;
        res.redirect        = redir;
        res.redirect_target = target;
        return res;
    endfunction

    task automatic add_case(input string name, input exec_issue_t pkt,
                            input exec_result_t expected);
        case_name.push_back(name);
        case_issue.push_back(pkt);
        case_expect.push_back(expected);
    endtask

    function automatic data_word_t lcg_next();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state;
    endfunction

    // Expected result built straight from the RV32I rules of each uop
    function automatic exec_result_t predict_result(input exec_issue_t pkt);
        exec_result_t res;
        data_word_t   a;
        data_word_t   b;
        data_word_t   value;
        data_word_t   target;
        logic         taken;
        res    = '0;
        a      = pkt.rs1_value;
        b      = pkt.use_imm ? pkt.imm : pkt.rs2_value;
        target = pkt.is_jalr ? ((a + pkt.imm) & ~32'd1) : (pkt.instr_addr + pkt.imm);
        case (pkt.uop)
            JAL:     value = pkt.instr_addr + (pkt.is_cjump ? 32'd2 : 32'd4);
            BEQ:     value = (a == b) ? 32'd1 : 32'd0;
            BNE:     value = (a != b) ? 32'd1 : 32'd0;
            BLT:     value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            BLTU:    value = (a < b) ? 32'd1 : 32'd0;
            BGE:     value = ($signed(a) >= $signed(b)) ? 32'd1 : 32'd0;
            BGEU:    value = (a >= b) ? 32'd1 : 32'd0;
            ADD:     value = a + b;
            AND:     value = a & b;
            OR:      value = a | b;
            XOR:     value = a ^ b;
            SLTI:    value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            SLTU:    value = (a < b) ? 32'd1 : 32'd0;
            SLL:     value = a << b[4:0];
            SRL:     value = a >> b[4:0];
            default: value = data_word_t'($signed(a) >>> b[4:0]);
        endcase
        taken = pkt.valid && (pkt.uop < LAST_JUMP_UOP) && (value != 32'd0);
        if (pkt.valid && pkt.rd != 5'd0) begin
            res.wb_valid = 1'b1;
            res.wb_rd    = pkt.rd;
            res.wb_data  = value;
        end
        if (taken) begin
            res.redirect        = 1'b1;
            res.redirect_target = target;
        end
        return res;
    endfunction

    // The uop steps through all sixteen codes, so each one is seen twice
    // Branches carry rd x0 and compare registers; only JAL may use is_jalr
    function automatic exec_issue_t random_packet(input int index);
        exec_issue_t pkt;
        data_word_t  ctrl;
        ctrl           = lcg_next();
        pkt            = '0;
        pkt.valid      = ctrl[27:25] != 3'd0;
        pkt.uop        = alu_uop_t'(index[3:0]);
        pkt.rs1_value  = lcg_next();
        pkt.rs2_value  = lcg_next();
        if (ctrl[24]) begin
            pkt.rs2_value = pkt.rs1_value;
        end
        pkt.imm        = lcg_next();
        pkt.instr_addr = lcg_next() & 32'hFFFF_FFFC;
        pkt.use_imm    = ctrl[23];
        pkt.is_jalr    = ctrl[22] && (pkt.uop == JAL);
        pkt.is_cjump   = ctrl[21];
        pkt.rd         = ctrl[20:16];
        if (pkt.uop != JAL && pkt.uop < LAST_JUMP_UOP) begin
            pkt.rd      = 5'd0;
            pkt.use_imm = 1'b0;
        end
        return pkt;
    endfunction

    //==========================================================================
    // Directed table
    //==========================================================================

    task automatic fill_table();
        add_case("idle_after_reset", '0, '0);
        add_case("add", make_issue(ADD, 32'h5, 32'h7, 32'h0, 32'h0, 3'b000, 5'd1),
                 make_result(1'b1, 5'd1, 32'd12, 1'b0, 32'h0));
        add_case("and", make_issue(AND, 32'hF0F0_1234, 32'h0FF0_FF00, 32'h0, 32'h0, 3'b000, 5'd3),
                 make_result(1'b1, 5'd3, 32'h00F0_1200, 1'b0, 32'h0));
        add_case("or", make_issue(OR, 32'hF000_000F, 32'h0F00_00F0, 32'h0, 32'h0, 3'b000, 5'd4),
                 make_result(1'b1, 5'd4, 32'hFF00_00FF, 1'b0, 32'h0));
        add_case("xor", make_issue(XOR, 32'hAAAA_5555, 32'hFFFF_0000, 32'h0, 32'h0, 3'b000, 5'd5),
                 make_result(1'b1, 5'd5, 32'h5555_5555, 1'b0, 32'h0));
        add_case("sll_low5", make_issue(SLL, 32'h3, 32'h24, 32'h0, 32'h0, 3'b000, 5'd6),
                 make_result(1'b1, 5'd6, 32'h30, 1'b0, 32'h0));
        add_case("srl", make_issue(SRL, 32'h8000_0000, 32'd31, 32'h0, 32'h0, 3'b000, 5'd7),
                 make_result(1'b1, 5'd7, 32'h1, 1'b0, 32'h0));
        add_case("sra_neg", make_issue(SRA, 32'h8000_0010, 32'h0, 32'h4, 32'h0, 3'b100, 5'd8),
                 make_result(1'b1, 5'd8, 32'hF800_0001, 1'b0, 32'h0));
        add_case("srai_imm", make_issue(SRA, 32'h7000_0000, 32'h0, 32'h404, 32'h0, 3'b100, 5'd9),
                 make_result(1'b1, 5'd9, 32'h0700_0000, 1'b0, 32'h0));
        add_case("slti_signed",
                 make_issue(SLTI, 32'hFFFF_FFFF, 32'h0, 32'h1, 32'h0, 3'b100, 5'd10),
                 make_result(1'b1, 5'd10, 32'h1, 1'b0, 32'h0));
        add_case("sltu_unsigned",
                 make_issue(SLTU, 32'hFFFF_FFFF, 32'h1, 32'h0, 32'h0, 3'b000, 5'd11),
                 make_result(1'b1, 5'd11, 32'h0, 1'b0, 32'h0));
        // Branches redirect to instr_addr plus imm and never write back
        add_case("beq_taken", make_issue(BEQ, 32'h1234, 32'h1234, 32'h10, 32'h100, 3'b000, 5'd0),
                 make_result(1'b0, 5'd0, 32'h0, 1'b1, 32'h110));
        add_case("beq_not", make_issue(BEQ, 32'h1234, 32'h1235, 32'h10, 32'h100, 3'b000, 5'd0),
                 '0);
        add_case("bne_taken", make_issue(BNE, 32'h1, 32'h2, 32'hFFFF_FFF8, 32'h200, 3'b000, 5'd0),
                 make_result(1'b0, 5'd0, 32'h0, 1'b1, 32'h1F8));
        add_case("bne_not",
                 make_issue(BNE, 32'h5, 32'h5, 32'hFFFF_FFF8, 32'h200, 3'b000, 5'd0),
                 '0);
        add_case("blt_taken",
                 make_issue(BLT, 32'hFFFF_FFFE, 32'h1, 32'h20, 32'h300, 3'b000, 5'd0),
                 make_result(1'b0, 5'd0, 32'h0, 1'b1, 32'h320));
        add_case("blt_not",
                 make_issue(BLT, 32'h1, 32'hFFFF_FFFE, 32'h20, 32'h300, 3'b000, 5'd0),
                 '0);
        add_case("bltu_taken",
                 make_issue(BLTU, 32'h1, 32'hFFFF_FFFE, 32'h40, 32'h400, 3'b000, 5'd0),
                 make_result(1'b0, 5'd0, 32'h0, 1'b1, 32'h440));
        add_case("bltu_not",
                 make_issue(BLTU, 32'hFFFF_FFFE, 32'h1, 32'h40, 32'h400, 3'b000, 5'd0),
                 '0);
        add_case("bge_taken", make_issue(BGE, 32'h3, 32'h3, 32'h8, 32'h500, 3'b000, 5'd0),
                 make_result(1'b0, 5'd0, 32'h0, 1'b1, 32'h508));
        add_case("bge_not",
                 make_issue(BGE, 32'hFFFF_FFFE, 32'h1, 32'h8, 32'h500, 3'b000, 5'd0),
                 '0);
        add_case("bgeu_taken",
                 make_issue(BGEU, 32'hFFFF_FFFE, 32'h1, 32'h100, 32'h600, 3'b000, 5'd0),
                 make_result(1'b0, 5'd0, 32'h0, 1'b1, 32'h700));
        add_case("bgeu_not",
                 make_issue(BGEU, 32'h1, 32'hFFFF_FFFE, 32'h100, 32'h600, 3'b000, 5'd0),
                 '0);
        // Jumps link to the next instruction and always redirect
        add_case("jal_full", make_issue(JAL, 32'h0, 32'h0, 32'h80, 32'h1000, 3'b000, 5'd1),
                 make_result(1'b1, 5'd1, 32'h1004, 1'b1, 32'h1080));
        add_case("jal_comp", make_issue(JAL, 32'h0, 32'h0, 32'hFFFF_FF00, 32'h1000, 3'b001, 5'd1),
                 make_result(1'b1, 5'd1, 32'h1002, 1'b1, 32'h0F00));
        add_case("jalr_full", make_issue(JAL, 32'h2001, 32'h0, 32'h10, 32'h3000, 3'b010, 5'd5),
                 make_result(1'b1, 5'd5, 32'h3004, 1'b1, 32'h2010));
        add_case("jalr_comp", make_issue(JAL, 32'h4000, 32'h0, 32'h7, 32'h3100, 3'b011, 5'd1),
                 make_result(1'b1, 5'd1, 32'h3102, 1'b1, 32'h4006));
        add_case("add_to_x0", make_issue(ADD, 32'h1, 32'h2, 32'h0, 32'h0, 3'b000, 5'd0), '0);
    endtask

    //==========================================================================
    // Stimulus and end of run
    //==========================================================================

    initial begin
        exec_issue_t pkt;
        int          total;
        arst_n    = 1'b1;
        check_en  = 1'b0;
        issue     = '0;
        rng_state = 32'd55253;
        fill_table();
        cycle_limit = RESET_CYCLES + case_name.size() + RANDOM_COUNT + PIPE_DEPTH
                    + TIMEOUT_MARGIN;
        // A real falling edge on the reset line clears every flop before the first clock
        #DRIVE_DELAY arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY arst_n = 1'b1;
        // Packets go out on consecutive cycles with no gap
        for (int i = 0; i < case_name.size(); i++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            issue    = case_issue[i];
            check_en = 1'b1;
            i_monitor.expect_result(case_name[i], case_expect[i]);
        end
        for (int i = 0; i < RANDOM_COUNT; i++) begin
            pkt = random_packet(i);
            @(posedge clk);
            #DRIVE_DELAY;
            issue = pkt;
            i_monitor.expect_result($sformatf("random_%0d", i), predict_result(pkt));
        end
        @(posedge clk);
        #DRIVE_DELAY;
        issue    = '0;
        check_en = 1'b0;
        total    = case_name.size() + RANDOM_COUNT;
        while (pass_count + fail_count < total) begin
            @(posedge clk);
        end
        $display("Checks: %0d passed, %0d failed, %0d assertion errors",
                 pass_count, fail_count, i_dut.i_chk.error_count);
        if (fail_count == 0 && i_dut.i_chk.error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the simulation timed out after %0d cycles", cycle_count);
            $display("Simulation failed");
            $finish;
        end
    end

endmodule : tb_execute_pipeline

`default_nettype wire

/* sources.f */
design/exec_pkg.sv
design/operand_select.sv
design/arithmetic_logic_unit.sv
design/branch_resolve.sv
design/execute_pipeline.sv
tests/exec_monitor.sv
tests/execute_pipeline_chk.sv
tests/tb_execute_pipeline.sv

/* Bender.yml */
package:
  name: execute_pipeline

sources:
  - design/exec_pkg.sv
  - design/operand_select.sv
  - design/arithmetic_logic_unit.sv
  - design/branch_resolve.sv
  - design/execute_pipeline.sv
  - target: test
    files:
      - tests/exec_monitor.sv
      - tests/execute_pipeline_chk.sv
      - tests/tb_execute_pipeline.sv
